// ==== hw/timerPkg.sv ====
package timerPkg;

	// bank geometry
	localparam int numChannels = 4;                    // timer channels in the bank
	localparam int chanWidth   = $clog2(numChannels);  // bits of a channel index
	localparam int countWidth  = 16;                   // counter and period width

	// prefix network used by every decrementer
	// 0 serial, 1 Brent-Kung, 2 Sklansky
	localparam int prefixSpeed = 2;

	// command kinds
	typedef enum logic [1:0] {
		oneShot,   // count down once, then go idle
		periodic,  // reload from period after each expiry
		stop       // halt the channel
	} timerMode;

	// one command per cycle from outside
	typedef struct packed {
		logic                  valid;  // sample strobe
		logic [chanWidth-1:0]  chan;   // target channel
		timerMode              mode;   // load kind or stop
		logic [countWidth-1:0] value;  // start count, also the period
	} timerCmd;

	// expiry report, valid is a single-cycle pulse
	typedef struct packed {
		logic                 valid;  // event strobe
		logic [chanWidth-1:0] chan;   // channel that expired
	} expiryEvt;

endpackage

// ==== hw/prefixAnd.sv ====
module prefixAnd #(
	parameter int width = 8,  // word width
	parameter int speed = 0   // 0 serial, 1 Brent-Kung, 2 Sklansky
) (
	input  logic [width-1:0] PI,  // propagate in
	output logic [width-1:0] PO   // running AND, bit i = &PI[i:0]
);

	localparam int depth    = $clog2(width);                    // tree levels
	localparam int bkStages = (depth > 0) ? 2 * depth - 1 : 0;  // up plus down sweep

	if (speed == 2) begin : sklansky
		// one row per level, row 0 is the input
		logic [depth:0][width-1:0] pt;

		assign pt[0] = PI;
		for (genvar l = 1; l <= depth; l++) begin : level
			for (genvar i = 0; i < width; i++) begin : node
				// upper half of each 2**l block takes the last bit of the lower half
				if (((i >> (l - 1)) % 2) == 1) begin : black
					assign pt[l][i] = pt[l-1][i] & pt[l-1][((i >> l) << l) + 2**(l-1) - 1];
				end else begin : white
					assign pt[l][i] = pt[l-1][i];  // lower half passes through
				end
			end : node
		end : level
		assign PO = pt[depth];
	end : sklansky

	else if (speed == 1) begin : brentKung
		// stages 1..depth reduce, the rest fill in
		logic [bkStages:0][width-1:0] pt;

		assign pt[0] = PI;

		// up-sweep
		// after level l, bit 2**l*k-1 holds the AND of its aligned 2**l block
		for (genvar l = 1; l <= depth; l++) begin : up
			for (genvar i = 0; i < width; i++) begin : node
				if (((i + 1) % (2**l)) == 0) begin : black
					assign pt[l][i] = pt[l-1][i] & pt[l-1][i - 2**(l-1)];
				end else begin : white
					assign pt[l][i] = pt[l-1][i];
				end
			end : node
		end : up

		// down-sweep, coarse to fine
		for (genvar l = depth - 1; l >= 1; l--) begin : down
			localparam int s = 2 * depth - l;  // stage of this level
			for (genvar i = 0; i < width; i++) begin : node
				// mid-block bits pick up the finished prefix just below their block
				if (i >= 2**l && ((i + 1) % (2**l)) == 2**(l-1)) begin : black
					assign pt[s][i] = pt[s-1][i] & pt[s-1][i - 2**(l-1)];
				end else begin : white
					assign pt[s][i] = pt[s-1][i];
				end
			end : node
		end : down

		assign PO = pt[bkStages];
	end : brentKung

	else begin : serial
		// ripple chain, smallest and slowest
		logic [width-1:0] pt;

		assign pt[0] = PI[0];
		for (genvar i = 1; i < width; i++) begin : node
			assign pt[i] = pt[i-1] & PI[i];
		end : node
		assign PO = pt;
	end : serial

endmodule

// ==== hw/decC.sv ====
module decC #(
	parameter int width = 8,  // word width
	parameter int speed = 0   // prefix structure, see prefixAnd
) (
	input  logic [width-1:0] A,   // operand
	input  logic             CI,  // carry in, subtracted from A
	output logic [width-1:0] Z,   // A - CI
	output logic             CO   // borrow out, A was zero and CI set
);

	logic [width:0] zeroRun;  // CI followed by inverted A
	logic [width:0] toggle;   // bit i flips when CI set and A[i-1:0] all zero

	// a decrement flips every bit up to and including the lowest one
	assign zeroRun = {~A, CI};

	prefixAnd #(
		.width(width + 1),
		.speed(speed)
	) prefix_i (
		.PI(zeroRun),
		.PO(toggle)
	);

	assign Z  = A ^ toggle[width-1:0];  // flip the masked bits
	assign CO = toggle[width];          // mask ran off the top

endmodule

// ==== hw/timerChannel.sv ====
module timerChannel (
	input  logic                            clk,
	input  logic                            arstN,
	input  logic                            load,       // start with loadMode and loadValue
	input  logic                            stop,       // halt the channel
	input  timerPkg::timerMode              loadMode,
	input  logic [timerPkg::countWidth-1:0] loadValue,
	input  logic                            tick,       // global count enable
	input  logic                            ack,        // arbiter took our expiry
	output logic                            pending     // expiry waiting for the arbiter
);

	import timerPkg::*;

	logic [countWidth-1:0] count;     // current count
	logic [countWidth-1:0] period;    // reload value
	logic [countWidth-1:0] countDec;  // count - tick
	logic                  borrow;    // count was zero on a tick
	logic                  active;    // channel is running
	logic                  expire;    // valid expiry this cycle
	timerMode              mode;

	decC #(
		.width(countWidth),
		.speed(prefixSpeed)
	) dec_i (
		.A (count),
		.CI(tick),
		.Z (countDec),
		.CO(borrow)
	);

	assign expire = active && borrow && !stop;  // stop wins over a borrow

	// count and period, load restarts
	always_ff @(posedge clk) begin
		if (load) begin
			count  <= loadValue;
			period <= loadValue;
		end else if (active && tick) begin
			if (borrow && mode == periodic)
				count <= period;  // wrap, next expiry in period+1 ticks
			else
				count <= countDec;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			active  <= 1'b0;
			pending <= 1'b0;
			mode    <= oneShot;
		end else begin
			if (load) begin
				active <= 1'b1;
				mode   <= loadMode;
			end else if (stop || (expire && mode == oneShot))
				active <= 1'b0;  // halted, or one-shot ran out
			// ack wins, a new expiry under ack merges into the one being reported
			if (ack)
				pending <= 1'b0;
			else if (expire)
				pending <= 1'b1;
		end
	end

endmodule

// ==== hw/cmdDecoder.sv ====
module cmdDecoder (
	input  logic                             clk,
	input  logic                             arstN,
	input  timerPkg::timerCmd                cmd,        // sampled when cmd.valid
	output logic [timerPkg::numChannels-1:0] load,       // one-hot load strobe
	output logic [timerPkg::numChannels-1:0] stop,       // one-hot stop strobe
	output timerPkg::timerMode               loadMode,   // shared by all channels
	output logic [timerPkg::countWidth-1:0]  loadValue   // shared by all channels
);

	import timerPkg::*;

	logic [numChannels-1:0] chanHot;  // target channel, zero without a command
	logic                   isStop;

	assign chanHot = cmd.valid ? (numChannels'(1) << cmd.chan) : '0;
	assign isStop  = (cmd.mode == timerPkg::stop);

	// strobes last exactly one cycle per command
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			load <= '0;
			stop <= '0;
		end else begin
			load <= isStop ? '0 : chanHot;
			stop <= isStop ? chanHot : '0;
		end
	end

	// payload, only the strobed channel looks at it
	always_ff @(posedge clk) begin
		if (cmd.valid) begin
			loadMode  <= cmd.mode;
			loadValue <= cmd.value;
		end
	end

endmodule

// ==== hw/expiryArbiter.sv ====
module expiryArbiter (
	input  logic                             clk,
	input  logic                             arstN,
	input  logic [timerPkg::numChannels-1:0] pending,  // one bit per channel
	output logic [timerPkg::numChannels-1:0] ack,      // one-hot, clears the winner
	output timerPkg::expiryEvt               evt       // registered event
);

	import timerPkg::*;

	logic [chanWidth-1:0] winner;      // lowest pending index
	logic                 anyPending;

	assign anyPending = |pending;

	// fixed priority, channel 0 first
	always_comb begin
		winner = '0;
		for (int i = numChannels - 1; i >= 0; i--) begin
			if (pending[i])
				winner = chanWidth'(i);  // lower index overwrites
		end
	end

	// lowest set bit, ack lands on the same edge that registers evt
	assign ack = pending & (~pending + numChannels'(1));

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			evt <= '0;
		end else begin
			evt.valid <= anyPending;  // pulse, the winner drops out right after
			evt.chan  <= winner;
		end
	end

endmodule

// ==== hw/timerBank.sv ====
module timerBank (
	input  logic               clk,
	input  logic               arstN,
	input  timerPkg::timerCmd  cmd,   // one command per cycle
	input  logic               tick,  // global count strobe
	output timerPkg::expiryEvt evt    // one expiry per pulse
);

	import timerPkg::*;

	logic [numChannels-1:0] load;       // decoder strobes
	logic [numChannels-1:0] stop;
	logic [numChannels-1:0] pending;    // channels to arbiter
	logic [numChannels-1:0] ack;        // arbiter back to channels
	timerMode               loadMode;
	logic [countWidth-1:0]  loadValue;

	cmdDecoder cmdDecoder_i (
		.clk      (clk),
		.arstN    (arstN),
		.cmd      (cmd),
		.load     (load),
		.stop     (stop),
		.loadMode (loadMode),
		.loadValue(loadValue)
	);

	for (genvar i = 0; i < numChannels; i++) begin : channel
		timerChannel timerChannel_i (
			.clk      (clk),
			.arstN    (arstN),
			.load     (load[i]),
			.stop     (stop[i]),
			.loadMode (loadMode),
			.loadValue(loadValue),
			.tick     (tick),
			.ack      (ack[i]),
			.pending  (pending[i])
		);
	end : channel

	expiryArbiter expiryArbiter_i (
		.clk    (clk),
		.arstN  (arstN),
		.pending(pending),
		.ack    (ack),
		.evt    (evt)
	);

endmodule

// ==== bench/tbClock.sv ====
module tbClock #(
	parameter int resetCycles = 8  // rising edges with arstN low
) (
	output logic clk,
	output logic arstN
);

	timeunit 1ns;
	timeprecision 100ps;

	// 10 ns period
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		arstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);  // release away from the sampling edge
		arstN = 1'b1;
	end

endmodule

// ==== bench/timerBank_properties.sv ====
module timerBankProperties (
	input logic                             clk,
	input logic                             arstN,
	input timerPkg::expiryEvt               evt,
	input logic [timerPkg::numChannels-1:0] pending
);

	timeunit 1ns;
	timeprecision 100ps;

	import timerPkg::*;

	int assertFails = 0;  // failed assertion count

	// evt register is cleared by the async reset
	evtQuietInReset: assert property (@(posedge clk) !arstN |-> !evt.valid)
		else begin
			assertFails++;
			$error("evt.valid high while arstN is low");
		end

	// an event only comes from a channel that was pending one cycle earlier
	evtFromPending: assert property (@(posedge clk) disable iff (!arstN)
		evt.valid |-> |($past(pending) & (numChannels'(1) << evt.chan)))
		else begin
			assertFails++;
			$error("evt.valid for channel %0d without a pending expiry", evt.chan);
		end

	// ack clears the winner, so the same channel cannot win twice in a row
	singlePulse: assert property (@(posedge clk) disable iff (!arstN)
		evt.valid && $past(evt.valid) |-> evt.chan != $past(evt.chan))
		else begin
			assertFails++;
			$error("evt.valid held for channel %0d on two cycles", evt.chan);
		end

endmodule

bind timerBank timerBankProperties props_i (
	.clk    (clk),
	.arstN  (arstN),
	.evt    (evt),
	.pending(pending)
);

// ==== bench/timerBank_tb.sv ====
module timerBank_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import timerPkg::*;

	localparam int resetCycles = 8;
	localparam int maxLines    = 128;  // rows the trace memory holds
	localparam int numCols     = 8;    // words per trace row
	localparam int slack       = 20;   // cycles allowed past the trace
	localparam string tracePath = "bench/timerBank_trace.txt";

	logic     clk;
	logic     arstN;
	timerCmd  cmd;
	logic     tick;
	expiryEvt evt;

	// columns: test cmdValid chan mode value tick evtValid evtChan
	logic [15:0] trace [0:maxLines*numCols-1];

	int numLines   = 0;
	int cycles     = 0;  // rising edges since reset release
	int cycleLimit = slack;

	tbClock #(
		.resetCycles(resetCycles)
	) clock_i (
		.clk  (clk),
		.arstN(arstN)
	);

	timerBank dut_i (
		.clk  (clk),
		.arstN(arstN),
		.cmd  (cmd),
		.tick (tick),
		.evt  (evt)
	);

	function automatic logic [15:0] traceWord(input int row, input int col);
		return trace[row*numCols + col];
	endfunction

	// test column to a readable name
	function automatic string testName(input logic [15:0] id);
		case (id)
			16'd1:   return "oneShotExpiry";
			16'd2:   return "periodicReload";
			16'd3:   return "sameEdgeOrder";
			16'd4:   return "stopAndReload";
			16'd5:   return "zeroLoad";
			default: return "unknown";
		endcase
	endfunction

	// applied on the falling edge, sampled by the next rising edge
	task automatic driveRow(input int row);
		cmd.valid = (traceWord(row, 1) != 16'd0);
		cmd.chan  = chanWidth'(traceWord(row, 2));
		cmd.mode  = timerMode'(2'(traceWord(row, 3)));
		cmd.value = traceWord(row, 4);
		tick      = (traceWord(row, 5) != 16'd0);
	endtask

	task automatic checkEvt(
		input string    name,
		input int       row,
		input expiryEvt expected,
		input expiryEvt actual
	);
		// chan only counts when an event is expected
		if (actual.valid !== expected.valid ||
				(expected.valid && actual.chan !== expected.chan)) begin
			$display("error: %s row %0d expected valid %0b chan %0d, actual valid %0b chan %0d",
				name, row, expected.valid, expected.chan, actual.valid, actual.chan);
			$display("TESTS FAILED");
			$fatal(1, "evt mismatch");
		end
	endtask

	// watchdog, limit set once the trace length is known
	always @(posedge clk) begin
		if (arstN) begin
			cycles++;
			if (cycles > cycleLimit) begin
				$display("timeout: trace not finished after %0d cycles", cycles);
				$display("TESTS FAILED");
				$fatal(1, "timeout");
			end
		end
	end

	initial begin
		expiryEvt expected;

		cmd  = '0;
		tick = 1'b0;

		$readmemh(tracePath, trace);
		// end marker has ff in the test column
		while (numLines < maxLines && traceWord(numLines, 0) != 16'h00ff)
			numLines++;
		if (numLines == 0 || numLines == maxLines) begin
			$display("trace file is empty or has no end marker");
			$display("TESTS FAILED");
			$fatal(1, "bad trace");
		end
		cycleLimit = numLines + slack;

		wait (arstN === 1'b1);  // released on a falling edge
		for (int row = 0; row < numLines; row++) begin
			driveRow(row);
			@(negedge clk);  // evt settled after the rising edge
			expected.valid = (traceWord(row, 6) != 16'd0);
			expected.chan  = chanWidth'(traceWord(row, 7));
			checkEvt(testName(traceWord(row, 0)), row, expected, evt);
		end

		if (dut_i.props_i.assertFails != 0) begin
			$display("%0d assertion failures in the bound checks", dut_i.props_i.assertFails);
			$display("TESTS FAILED");
			$fatal(1, "assertion failure");
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

// ==== bench/timerBank_trace.txt ====
// test cmdValid chan mode value tick | expected evtValid evtChan, hex, one row per clock
// mode 0 oneShot 1 periodic 2 stop, test ff ends the trace
1 1 0 0 0003 1 0 0  // ch0 oneShot 3
1 0 0 0 0000 1 0 0  // load lands
1 0 0 0 0000 1 0 0
1 0 0 0 0000 1 0 0
1 0 0 0 0000 1 0 0
1 0 0 0 0000 1 0 0  // borrow
1 0 0 0 0000 1 1 0  // single expiry
1 0 0 0 0000 1 0 0
1 0 0 0 0000 1 0 0
1 0 0 0 0000 1 0 0
1 0 0 0 0000 1 0 0
2 1 1 1 0002 1 0 0  // ch1 periodic 2
2 0 0 0 0000 1 0 0
2 0 0 0 0000 1 0 0
2 0 0 0 0000 1 0 0
2 0 0 0 0000 1 0 0
2 0 0 0 0000 1 1 1
2 0 0 0 0000 1 0 0
2 0 0 0 0000 1 0 0
2 0 0 0 0000 1 1 1  // every 3 cycles
2 0 0 0 0000 1 0 0
2 0 0 0 0000 1 0 0
2 0 0 0 0000 1 1 1
2 0 0 0 0000 0 0 0  // tick low 4 cycles
2 0 0 0 0000 0 0 0
2 0 0 0 0000 0 0 0
2 0 0 0 0000 0 0 0
2 0 0 0 0000 1 0 0
2 0 0 0 0000 1 0 0
2 0 0 0 0000 1 1 1  // 4 cycles late
2 0 0 0 0000 1 0 0
2 0 0 0 0000 1 0 0
2 1 1 2 0000 1 1 1  // stop ch1
2 0 0 0 0000 1 0 0
3 1 0 0 0005 1 0 0  // ch0 5, ch2 4, ch3 3 all borrow together
3 1 2 0 0004 1 0 0
3 1 3 0 0003 1 0 0
3 0 0 0 0000 1 0 0
3 0 0 0 0000 1 0 0
3 0 0 0 0000 1 0 0
3 0 0 0 0000 1 0 0
3 0 0 0 0000 1 0 0  // three pending
3 0 0 0 0000 1 1 0
3 0 0 0 0000 1 1 2
3 0 0 0 0000 1 1 3
3 0 0 0 0000 1 0 0
3 0 0 0 0000 1 0 0
4 1 2 0 0004 1 0 0  // ch2 oneShot 4
4 0 0 0 0000 1 0 0
4 1 2 2 0000 1 0 0  // stop before expiry
4 0 0 0 0000 1 0 0
4 0 0 0 0000 1 0 0
4 0 0 0 0000 1 0 0
4 0 0 0 0000 1 0 0  // would have fired here
4 0 0 0 0000 1 0 0
4 1 2 0 0004 1 0 0  // reload restarts at 4
4 0 0 0 0000 1 0 0
4 0 0 0 0000 1 0 0
4 0 0 0 0000 1 0 0
4 0 0 0 0000 1 0 0
4 0 0 0 0000 1 0 0
4 0 0 0 0000 1 0 0
4 0 0 0 0000 1 1 2
4 0 0 0 0000 1 0 0
5 1 3 0 0000 1 0 0  // ch3 oneShot 0
5 0 0 0 0000 1 0 0
5 0 0 0 0000 1 0 0  // borrow on first tick
5 0 0 0 0000 1 1 3
5 0 0 0 0000 1 0 0
5 1 1 1 0000 1 0 0  // ch1 periodic 0, borrows every tick
5 0 0 0 0000 1 0 0
5 0 0 0 0000 1 0 0
5 0 0 0 0000 1 1 1
5 0 0 0 0000 1 0 0  // expiry under ack merged
5 0 0 0 0000 1 1 1
5 0 0 0 0000 1 0 0
5 1 1 2 0000 1 1 1  // stop ch1
5 0 0 0 0000 1 0 0
5 0 0 0 0000 1 0 0
5 0 0 0 0000 1 0 0
ff 0 0 0 0000 0 0 0

// ==== vlog.f ====
hw/timerPkg.sv
hw/prefixAnd.sv
hw/decC.sv
hw/timerChannel.sv
hw/cmdDecoder.sv
hw/expiryArbiter.sv
hw/timerBank.sv
bench/tbClock.sv
bench/timerBank_properties.sv
bench/timerBank_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the timer bank testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
	--top-module timerBank_tb -f vlog.f -o simv

# a failing run exits nonzero, keep the log for the verdict
status=0
./obj_dir/simv > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -qx "TESTS PASSED" sim.log; then
	echo "simulation ok"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
